// ==== sources.f ====
source/audio_pkg.sv
source/audio_ctrl.sv
source/tone_gen.sv
source/sample_mixer.sv
source/sample_fifo.sv
source/sigma_delta_dac.sv
source/audio_top.sv
verification/audio_assertions.sv
verification/audio_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := audio_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/audio_tb.sv ====
`timescale 1ns/1ps

module audio_tb import audio_pkg::*; ();

  localparam int FIFO_DEPTH     = 4;
  localparam int CLK_DIV        = 4;
  localparam int DAC_OSR        = 16;
  localparam int NUM_SEG        = 6;
  localparam int SEG_SAMPLES    = 40;
  localparam int DC_SETTLE      = 4;
  localparam int DC_ENABLES     = 8192;
  localparam int SAMPLE_CYCLES  = DAC_OSR * CLK_DIV;
  localparam int DRAIN_CYCLES   = (FIFO_DEPTH + 2) * SAMPLE_CYCLES;
  localparam int IDLE_CYCLES    = 2 * SAMPLE_CYCLES;
  localparam int SEG_CYCLES     = (SEG_SAMPLES + 1) * SAMPLE_CYCLES + DRAIN_CYCLES + 16;
  localparam int DC_CYCLES      = (DC_SETTLE + 1) * SAMPLE_CYCLES + DC_ENABLES * CLK_DIV
                                  + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 8 + IDLE_CYCLES + NUM_SEG * SEG_CYCLES + DC_CYCLES + 1000;

  logic        sys_clk = 1'b0;
  logic        reset_i;
  reg_write_t  reg_wr_i;
  pcm_t        pcm_o;
  logic        pcm_valid_o;
  logic        audio_o;
  logic        acc1_overflow_o;
  logic        acc2_overflow_o;

  logic [31:0] rng_state = 32'h6fc7_c916;
  int          error_count  = 0;
  int          cycle_count  = 0;
  int          sample_count = 0;
  logic        idle_phase   = 1'b1;

  // Mirror of the tone and mixer state
  int          m_period [NUM_CH] = '{0, 0, 0};
  int          m_count  [NUM_CH] = '{0, 0, 0};
  int          m_vol    [NUM_CH] = '{0, 0, 0};
  logic [2:0]  m_level = '0;
  logic [2:0]  m_en    = '0;

  audio_top dut0 (
    .sys_clk         (sys_clk),
    .reset_i         (reset_i),
    .reg_wr_i        (reg_wr_i),
    .pcm_o           (pcm_o),
    .pcm_valid_o     (pcm_valid_o),
    .audio_o         (audio_o),
    .acc1_overflow_o (acc1_overflow_o),
    .acc2_overflow_o (acc2_overflow_o)
  );

  always #20 sys_clk = ~sys_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(input int span, output int value);
    rng_state = xorshift32(rng_state);
    value = int'(rng_state % 32'(span));
  endtask

  task automatic check_equal(input longint actual, input longint expected, input string what);
    if (actual != expected) begin
      error_count++;
      $display("mismatch at %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // Expected sample from the current tone state
  function automatic int model_sample();
    int sum;
    sum = 0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (m_en[ch] && !m_level[ch]) sum = sum - m_vol[ch] * 512;
      else sum = sum + m_vol[ch] * 512;
    end
    return sum;
  endfunction

  task automatic model_advance();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      m_count[ch]++;
      if (m_count[ch] >= ((m_period[ch] > 1) ? m_period[ch] : 1)) begin
        m_count[ch] = 0;
        m_level[ch] = ~m_level[ch]; // Half period done
      end
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [15:0] data);
    @(posedge sys_clk);
    #2;
    reg_wr_i.valid       = 1'b1;
    reg_wr_i.addr        = addr;
    reg_wr_i.data.period = data;
    @(posedge sys_clk);
    #2;
    reg_wr_i.valid = 1'b0;
  endtask

  task automatic write_period(input int ch, input int period);
    write_reg(reg_addr_e'(ch), 16'(period));
    m_period[ch] = period;
    m_count[ch]  = 0;
    m_level[ch]  = 1'b1; // Channel restarts high
  endtask

  task automatic write_mix(input logic run);
    mix_ctrl_t mix;
    mix.run     = run;
    mix.vol2    = 4'(m_vol[2]);
    mix.vol1    = 4'(m_vol[1]);
    mix.vol0    = 4'(m_vol[0]);
    mix.tone_en = m_en;
    write_reg(MIX_CTRL, mix);
  endtask

  task automatic wait_samples(input int count);
    int start;
    start = sample_count;
    while (sample_count < start + count) @(negedge sys_clk);
  endtask

  task automatic run_segment(input int seg);
    int ch;
    int p;
    if (seg == 0) begin
      for (int i = 0; i < NUM_CH; i++) begin
        draw(9, p);
        write_period(i, p + 1);
      end
    end else begin
      draw(NUM_CH, ch);
      draw(9, p);
      write_period(ch, (seg == 3) ? 0 : p + 1); // One segment uses period 0
    end
    for (int i = 0; i < NUM_CH; i++) draw(16, m_vol[i]);
    draw(8, p);
    m_en = 3'(p);
    write_mix(1'b1);
    wait_samples(SEG_SAMPLES);
    write_mix(1'b0);
    repeat (DRAIN_CYCLES) @(posedge sys_clk);
  endtask

  task automatic dc_density();
    int v;
    int enables;
    int ones;
    int expected_ones;
    int diff;
    draw(15, v);
    v = v + 1;
    for (int i = 0; i < NUM_CH; i++) m_vol[i] = v;
    m_en = '0;
    write_mix(1'b1);
    wait_samples(DC_SETTLE);
    enables = 0;
    ones    = 0;
    while (enables < DC_ENABLES) begin
      @(negedge sys_clk);
      if (dut0.dac_en) begin
        enables++;
        if (audio_o) ones++;
      end
    end
    write_mix(1'b0);
    repeat (DRAIN_CYCLES) @(posedge sys_clk);
    expected_ones = DC_ENABLES * (3 * v * 512 + 32768) / 65536;
    diff = (ones > expected_ones) ? ones - expected_ones : expected_ones - ones;
    check_equal(longint'(diff * 100 <= expected_ones), 1,
                $sformatf("audio_o density %0d ones near %0d", ones, expected_ones));
  endtask

  // Output monitor sampling away from the rising edge
  always @(negedge sys_clk) begin
    if (!reset_i) begin
      check_equal(longint'({acc1_overflow_o, acc2_overflow_o}), 0, "DAC overflow flags");
      if (idle_phase) begin
        check_equal(longint'(pcm_valid_o), 0, "pcm_valid_o while run is 0");
        check_equal(longint'(audio_o), 0, "audio_o while run is 0");
      end
      if (pcm_valid_o) begin
        check_equal(longint'(pcm_o), longint'(model_sample()), "pcm sample");
        model_advance();
        sample_count++;
      end
    end
  end

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  initial begin
    reset_i  = 1'b1;
    reg_wr_i = '0;
    repeat (4) @(posedge sys_clk);
    #2;
    reset_i = 1'b0;
    repeat (IDLE_CYCLES) @(posedge sys_clk);
    idle_phase = 1'b0;
    for (int seg = 0; seg < NUM_SEG; seg++) run_segment(seg);
    dc_density();
    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== verification/audio_assertions.sv ====
`timescale 1ns/1ps

module audio_assertions import audio_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                              sys_clk,
  input logic                              reset_i,
  input reg_write_t                        reg_wr_i,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0] credit_cnt_i,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0] fifo_count_i,
  input logic                              push_i,
  input logic                              pcm_valid_i,
  input logic                              gen_i
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic run_q; // Run bit as last written on the register port

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      run_q <= 1'b0;
    end else if (reg_wr_i.valid && (reg_wr_i.addr == MIX_CTRL)) begin
      run_q <= reg_wr_i.data.mix.run;
    end
  end

  credit_bound: assert property (@(posedge sys_clk) disable iff (reset_i)
    credit_cnt_i <= CW'(FIFO_DEPTH))
    else $error("credit count above FIFO depth");

  push_when_full: assert property (@(posedge sys_clk) disable iff (reset_i)
    push_i |-> (fifo_count_i != CW'(FIFO_DEPTH)))
    else $error("sample pushed into a full FIFO");

  // Valid is a single-cycle pulse
  valid_pulse: assert property (@(posedge sys_clk) disable iff (reset_i)
    pcm_valid_i |=> !pcm_valid_i)
    else $error("pcm_valid_o longer than one cycle");

  gen_needs_run: assert property (@(posedge sys_clk) disable iff (reset_i)
    gen_i |-> run_q)
    else $error("gen while run is 0");

endmodule

bind audio_top audio_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) assert0 (
  .sys_clk      (sys_clk),
  .reset_i      (reset_i),
  .reg_wr_i     (reg_wr_i),
  .credit_cnt_i (ctrl0.credit_cnt_q),
  .fifo_count_i (fifo0.count_q),
  .push_i       (sample.valid),
  .pcm_valid_i  (pcm_valid_o),
  .gen_i        (gen)
);

// ==== source/audio_top.sv ====
`timescale 1ns/1ps

module audio_top import audio_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int CLK_DIV    = 4,
  parameter int DAC_OSR    = 16
) (
  input  logic       sys_clk,
  input  logic       reset_i,
  input  reg_write_t reg_wr_i,
  output pcm_t       pcm_o,
  output logic       pcm_valid_o,
  output logic       audio_o,
  output logic       acc1_overflow_o,
  output logic       acc2_overflow_o
);

  logic              gen;
  logic              credit;
  logic              dac_en;
  logic              pop;
  logic              fifo_empty;
  reg_write_t        period_wr;
  mix_ctrl_t         mix_ctrl;
  logic [NUM_CH-1:0] levels;
  sample_t           sample;
  pcm_t              fifo_pcm;

  audio_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CLK_DIV    (CLK_DIV)
  ) ctrl0 (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .reg_wr_i    (reg_wr_i),
    .credit_i    (credit),
    .gen_o       (gen),
    .period_wr_o (period_wr),
    .mix_ctrl_o  (mix_ctrl),
    .dac_en_o    (dac_en)
  );

  tone_gen tone0 (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .gen_i       (gen),
    .period_wr_i (period_wr),
    .levels_o    (levels)
  );

  sample_mixer mixer0 (
    .sys_clk    (sys_clk),
    .reset_i    (reset_i),
    .gen_i      (gen),
    .levels_i   (levels),
    .mix_ctrl_i (mix_ctrl),
    .sample_o   (sample)
  );

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
    .sys_clk  (sys_clk),
    .reset_i  (reset_i),
    .sample_i (sample),
    .pop_i    (pop),
    .pcm_o    (fifo_pcm),
    .empty_o  (fifo_empty),
    .credit_o (credit)
  );

  sigma_delta_dac #(.DAC_OSR(DAC_OSR)) dac0 (
    .sys_clk         (sys_clk),
    .reset_i         (reset_i),
    .dac_en_i        (dac_en),
    .empty_i         (fifo_empty),
    .pcm_i           (fifo_pcm),
    .pop_o           (pop),
    .pcm_o           (pcm_o),
    .pcm_valid_o     (pcm_valid_o),
    .audio_o         (audio_o),
    .acc1_overflow_o (acc1_overflow_o),
    .acc2_overflow_o (acc2_overflow_o)
  );

endmodule

// ==== source/sigma_delta_dac.sv ====
`timescale 1ns/1ps

module sigma_delta_dac import audio_pkg::*; #(
  parameter int DAC_OSR = 16
) (
  input  logic sys_clk,
  input  logic reset_i,
  input  logic dac_en_i,
  input  logic empty_i,
  input  pcm_t pcm_i,
  output logic pop_o,
  output pcm_t pcm_o,
  output logic pcm_valid_o,
  output logic audio_o,
  output logic acc1_overflow_o,
  output logic acc2_overflow_o
);

  localparam int OW     = (DAC_OSR > 1) ? $clog2(DAC_OSR) : 1;
  localparam int ACC1_W = 20;
  localparam int ACC2_W = 24;
  localparam int SW     = ACC2_W + 1; // Room to see an overflow
  localparam logic signed [SW-1:0] FB_FULL = SW'(65536);
  localparam logic signed [SW-1:0] MID     = SW'(32768);

  logic [OW-1:0]            osr_cnt_q;
  logic                     started_q;
  pcm_t                     hold_q;
  logic                     pcm_valid_q;
  logic                     audio_q;
  logic                     ovf1_q;
  logic                     ovf2_q;
  logic signed [ACC1_W-1:0] acc1_q;
  logic signed [ACC1_W-1:0] acc1_new;
  logic signed [ACC2_W-1:0] acc2_q;
  logic signed [ACC2_W-1:0] acc2_new;
  logic signed [SW-1:0]     in_ext;
  logic signed [SW-1:0]     fb_ext;
  logic signed [SW-1:0]     acc1_sum;
  logic signed [SW-1:0]     acc2_sum;
  logic [15:0]              offset_bin;
  logic                     step;

  assign pop_o = dac_en_i && (osr_cnt_q == '0) && !empty_i;
  assign step  = dac_en_i && started_q; // Silent until the first sample

  assign offset_bin = {~hold_q[15], hold_q[14:0]};
  assign in_ext     = SW'(offset_bin);
  assign fb_ext     = audio_q ? FB_FULL : '0;

  // Second integrator takes the updated first one, NTF is (1-z^-1)^2
  assign acc1_sum = SW'(acc1_q) + in_ext - fb_ext;
  assign acc1_new = acc1_sum[ACC1_W-1:0];
  assign acc2_sum = SW'(acc2_q) + SW'(acc1_new) + MID - fb_ext; // Recentred feedback
  assign acc2_new = acc2_sum[ACC2_W-1:0];

  always_ff @(posedge sys_clk) begin
    if (pop_o) hold_q <= pcm_i;
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      osr_cnt_q   <= '0;
      started_q   <= 1'b0;
      pcm_valid_q <= 1'b0;
      acc1_q      <= '0;
      acc2_q      <= '0;
      audio_q     <= 1'b0;
      ovf1_q      <= 1'b0;
      ovf2_q      <= 1'b0;
    end else begin
      pcm_valid_q <= pop_o;
      if (pop_o) started_q <= 1'b1;
      if (dac_en_i) begin
        osr_cnt_q <= (osr_cnt_q == OW'(DAC_OSR - 1)) ? '0 : osr_cnt_q + 1'b1;
      end
      if (step) begin
        acc1_q  <= acc1_new;
        acc2_q  <= acc2_new;
        audio_q <= ~acc2_new[ACC2_W-1]; // One when the second integrator is non-negative
        // Sticky until reset
        if (SW'(acc1_new) != acc1_sum) ovf1_q <= 1'b1;
        if (SW'(acc2_new) != acc2_sum) ovf2_q <= 1'b1;
      end
    end
  end

  assign pcm_o           = hold_q;
  assign pcm_valid_o     = pcm_valid_q;
  assign audio_o         = audio_q;
  assign acc1_overflow_o = ovf1_q;
  assign acc2_overflow_o = ovf2_q;

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo import audio_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic    sys_clk,
  input  logic    reset_i,
  input  sample_t sample_i,
  input  logic    pop_i,
  output pcm_t    pcm_o,
  output logic    empty_o,
  output logic    credit_o
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  pcm_t          mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  // Wrap at FIFO_DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = sample_i.valid; // Credits guarantee room
  assign pop  = pop_i && (count_q != '0);

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr_q] <= sample_i.pcm;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Show-ahead head
  assign pcm_o    = mem[rd_ptr_q];
  assign empty_o  = (count_q == '0);
  assign credit_o = pop; // A freed slot goes back to the generator

endmodule

// ==== source/sample_mixer.sv ====
`timescale 1ns/1ps

module sample_mixer import audio_pkg::*; (
  input  logic              sys_clk,
  input  logic              reset_i,
  input  logic              gen_i,
  input  logic [NUM_CH-1:0] levels_i,
  input  mix_ctrl_t         mix_ctrl_i,
  output sample_t           sample_o
);

  logic [3:0] vol [NUM_CH];
  pcm_t       mix_sum;
  pcm_t       pcm_q;
  logic       valid_q;

  // Volume step is 512, a disabled tone contributes a constant
  function automatic pcm_t contribution(input logic [3:0] v, input logic en,
                                        input logic level);
    pcm_t mag;
    mag = pcm_t'({3'b000, v, 9'd0});
    return (en && !level) ? -mag : mag;
  endfunction

  assign vol[0] = mix_ctrl_i.vol0;
  assign vol[1] = mix_ctrl_i.vol1;
  assign vol[2] = mix_ctrl_i.vol2;

  // Worst case is 3 x 7680 so the sum stays in range
  always_comb begin
    mix_sum = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      mix_sum = mix_sum + contribution(vol[ch], mix_ctrl_i.tone_en[ch], levels_i[ch]);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= gen_i; // Push one cycle after gen
    end
  end

  always_ff @(posedge sys_clk) begin
    if (gen_i) begin
      pcm_q <= mix_sum;
    end
  end

  assign sample_o = '{valid: valid_q, pcm: pcm_q};

endmodule

// ==== source/tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen import audio_pkg::*; (
  input  logic              sys_clk,
  input  logic              reset_i,
  input  logic              gen_i,
  input  reg_write_t        period_wr_i,
  output logic [NUM_CH-1:0] levels_o
);

  logic [15:0]       period_q [NUM_CH];
  logic [15:0]       count_q  [NUM_CH];
  logic [NUM_CH-1:0] level_q;

  // A period of zero runs like a period of one
  function automatic logic [15:0] limit_of(input logic [15:0] period);
    return (period == 16'd0) ? 16'd1 : period;
  endfunction

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        period_q[ch] <= '0;
        count_q[ch]  <= '0;
      end
      level_q <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (period_wr_i.valid && (period_wr_i.addr == reg_addr_e'(ch))) begin
          // Restart the channel phase
          period_q[ch] <= period_wr_i.data.period;
          count_q[ch]  <= '0;
          level_q[ch]  <= 1'b1;
        end else if (gen_i) begin
          if (count_q[ch] >= limit_of(period_q[ch]) - 16'd1) begin
            count_q[ch] <= '0;
            level_q[ch] <= ~level_q[ch]; // Half period done
          end else begin
            count_q[ch] <= count_q[ch] + 16'd1;
          end
        end
      end
    end
  end

  assign levels_o = level_q;

endmodule

// ==== source/audio_ctrl.sv ====
`timescale 1ns/1ps

module audio_ctrl import audio_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int CLK_DIV    = 4
) (
  input  logic       sys_clk,
  input  logic       reset_i,
  input  reg_write_t reg_wr_i,
  input  logic       credit_i,
  output logic       gen_o,
  output reg_write_t period_wr_o,
  output mix_ctrl_t  mix_ctrl_o,
  output logic       dac_en_o
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);
  localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  mix_ctrl_t     mix_ctrl_q;
  logic [CW-1:0] credit_cnt_q;
  logic [DW-1:0] div_cnt_q;
  logic          mix_wr;

  assign mix_wr = reg_wr_i.valid && (reg_wr_i.addr == MIX_CTRL);

  // Period writes pass straight on, tone_gen registers them
  always_comb begin
    period_wr_o       = reg_wr_i;
    period_wr_o.valid = reg_wr_i.valid && (reg_wr_i.addr != MIX_CTRL);
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      mix_ctrl_q <= '0;
    end else if (mix_wr) begin
      mix_ctrl_q <= reg_wr_i.data.mix;
    end
  end

  assign mix_ctrl_o = mix_ctrl_q;

  // One sample per cycle as long as FIFO space is promised
  assign gen_o = mix_ctrl_q.run && (credit_cnt_q != '0);

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      credit_cnt_q <= CW'(FIFO_DEPTH);
    end else begin
      case ({gen_o, credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q; // Both or neither cancel out
      endcase
    end
  end

  // DAC clock enable, one cycle in CLK_DIV
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      div_cnt_q <= '0;
    end else if (div_cnt_q == DW'(CLK_DIV - 1)) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  assign dac_en_o = (div_cnt_q == DW'(CLK_DIV - 1));

endmodule

// ==== source/audio_pkg.sv ====
package audio_pkg;

  // Number of square-wave tone channels
  localparam int NUM_CH = 3;

  // Register map of the write port
  typedef enum logic [1:0] {
    PERIOD0  = 2'd0,
    PERIOD1  = 2'd1,
    PERIOD2  = 2'd2,
    MIX_CTRL = 2'd3
  } reg_addr_e;

  // Mixer control word, MSB first
  typedef struct packed {
    logic       run;     // Generator runs while set
    logic [3:0] vol2;
    logic [3:0] vol1;
    logic [3:0] vol0;
    logic [2:0] tone_en; // One bit per channel
  } mix_ctrl_t;

  // The same data word seen as a tone period or as a mixer control word
  typedef union packed {
    logic [15:0] period;
    mix_ctrl_t   mix;
  } reg_data_u;

  typedef struct packed {
    logic      valid;
    reg_addr_e addr;
    reg_data_u data;
  } reg_write_t;

  typedef logic signed [15:0] pcm_t;

  typedef struct packed {
    logic valid;
    pcm_t pcm;
  } sample_t;

endpackage
